//--- Makefile
TOP = tb_bus_subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -o sim_tb -f files.f
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
hw/bus_pkg.sv
hw/sys_bus_if.sv
hw/bus_arbiter.sv
hw/bus_ctrl_fsm.sv
hw/bus_beat_engine.sv
hw/bus_read_buffer.sv
hw/intr_bus_controller.sv
hw/mem_slave.sv
hw/bus_subsystem_top.sv
test/tb_bus_subsystem.sv

//--- hw/bus_arbiter.sv
// ###########################
// Two-master bus arbiter and router
// ###########################
`timescale 1ns/100ps

module bus_arbiter (
   input  logic      bus_clk,
   input  logic      rst,
   input  logic      br_0,
   input  logic      br_1,
   output logic      bg_0,
   output logic      bg_1,
   sys_bus_if.slave  m0,
   sys_bus_if.slave  m1,
   sys_bus_if.master mem
);
   // Master 1 won the most recent grant
   logic last_1;
   logic keep_0;
   logic keep_1;
   logic pick_1;
   logic next_bg_0;
   logic next_bg_1;

   // Owner keeps the bus while its request stays up
   assign keep_0 = bg_0 & br_0;
   assign keep_1 = bg_1 & br_1;
   // On contention the master that lost last time wins
   assign pick_1 = br_1 & (!br_0 | !last_1);

   always_comb begin
      if (keep_0 || keep_1) begin
         next_bg_0 = keep_0;
         next_bg_1 = keep_1;
      end else begin
         next_bg_0 = br_0 & !pick_1;
         next_bg_1 = pick_1;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         bg_0   <= 1'b0;
         bg_1   <= 1'b0;
         last_1 <= 1'b0;
      end else begin
         bg_0 <= next_bg_0;
         bg_1 <= next_bg_1;
         if (next_bg_0) begin
            last_1 <= 1'b0;
         end else if (next_bg_1) begin
            last_1 <= 1'b1;
         end
      end
   end

   // Strobes only pass for the granted master
   assign mem.valid = (bg_0 & m0.valid) | (bg_1 & m1.valid);
   assign mem.wbeat = (bg_0 & m0.wbeat) | (bg_1 & m1.wbeat);
   assign mem.addr  = bg_1 ? m1.addr : m0.addr;
   assign mem.rw    = bg_1 ? m1.rw : m0.rw;
   assign mem.wdata = bg_1 ? m1.wdata : m0.wdata;

   // Return path, the waiting master sees ack low
   assign m0.ack   = bg_0 & mem.ack;
   assign m1.ack   = bg_1 & mem.ack;
   assign m0.rdata = bg_0 ? mem.rdata : '0;
   assign m1.rdata = bg_1 ? mem.rdata : '0;

   a_one_grant: assert property (
      @(posedge bus_clk) disable iff (rst)
      !(bg_0 && bg_1)
   ) else $error("FAILED %0t: both bus grants high", $time);

endmodule

//--- hw/bus_beat_engine.sv
// ###########################
// Address phase, beat counter and
// write word select
// ###########################
`timescale 1ns/100ps

module bus_beat_engine (
   input  logic                 bus_clk,
   input  logic                 rst,
   input  bus_pkg::ctrl_state_t state,
   input  bus_pkg::line_t       wdata_line,
   input  bus_pkg::bus_addr_t   req_addr,
   input  logic                 req_wr,
   output bus_pkg::beat_idx_t   beat,
   output logic                 last_beat,
   sys_bus_if.master            bus
);
   import bus_pkg::*;

   logic in_addr;
   logic in_xfer;

   assign in_addr = (state == ADDR);
   assign in_xfer = (state == WRITE) || (state == READ);

   // Address phase lasts exactly one cycle
   assign bus.valid = in_addr;
   assign bus.addr  = in_addr ? req_addr : '0;
   assign bus.rw    = in_addr & req_wr;

   // Write beat held until the slave acks it
   assign bus.wbeat = (state == WRITE);
   // Lowest word first
   assign bus.wdata = wdata_line[BUS_W*beat +: BUS_W];

   // Beat count advances on each ack
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         beat <= '0;
      end else if (in_addr) begin
         beat <= '0;
      end else if (in_xfer && bus.ack) begin
         beat <= beat + 1'b1;
      end
   end

   // Final ack ends the transfer
   assign last_beat = in_xfer && bus.ack && (beat == beat_idx_t'(BEATS - 1));

   // Slave and arbiter only ack during a data phase of this master
   a_ack_in_xfer: assert property (
      @(posedge bus_clk) disable iff (rst)
      bus.ack |-> in_xfer
   ) else $error("FAILED %0t: ack outside a data phase", $time);

endmodule

//--- hw/bus_ctrl_fsm.sv
// ###########################
// Controller FSM, request decode
// ###########################
`timescale 1ns/100ps

module bus_ctrl_fsm (
   input  logic                 bus_clk,
   input  logic                 rst,
   input  logic                 en,
   input  logic                 wr,
   input  logic                 bg,
   input  logic                 last_beat,
   output logic                 br,
   output bus_pkg::ctrl_state_t state
);
   import bus_pkg::*;

   ctrl_state_t next_state;

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            // New line request from the unit
            if (en) begin
               next_state = REQ;
            end
         end
         REQ: begin
            // Hold the request until the arbiter grants
            if (bg) begin
               next_state = ADDR;
            end
         end
         ADDR: begin
            // Direction comes from the latched request
            next_state = wr ? WRITE : READ;
         end
         WRITE, READ: begin
            if (last_beat) begin
               next_state = DONE;
            end
         end
         DONE: begin
            next_state = IDLE;
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

   // Bus request from REQ through the final beat
   assign br = state inside {REQ, ADDR, WRITE, READ};

   // Past REQ the arbiter must still hold the grant for this controller
   a_xfer_granted: assert property (
      @(posedge bus_clk) disable iff (rst)
      (state inside {ADDR, WRITE, READ}) |-> bg
   ) else $error("FAILED %0t: controller on the bus without bg", $time);

endmodule

//--- hw/bus_pkg.sv
// ###########################
// Bus and line widths, width types
// and the controller state encoding
// ###########################
package bus_pkg;

   // Bus word and unit line geometry
   localparam int BUS_W  = 32;
   localparam int LINE_W = 128;
   localparam int ADDR_W = 16;
   localparam int BEATS  = LINE_W / BUS_W;
   localparam int BEAT_W = $clog2(BEATS);

   // Memory organization, one entry per 16-byte line
   localparam int MEM_LINES = 64;
   localparam int IDX_W     = $clog2(MEM_LINES);
   // Byte offset bits below the line index
   localparam int LINE_OFS  = $clog2(LINE_W / 8);

   typedef logic [BUS_W-1:0]  bus_word_t;
   typedef logic [LINE_W-1:0] line_t;
   typedef logic [ADDR_W-1:0] bus_addr_t;
   typedef logic [BEAT_W-1:0] beat_idx_t;
   typedef logic [IDX_W-1:0]  line_idx_t;

   // Controller sequence: request, address phase, four beats, done
   typedef enum logic [2:0] {
      IDLE,
      REQ,
      ADDR,
      WRITE,
      READ,
      DONE
   } ctrl_state_t;

endpackage

//--- hw/bus_read_buffer.sv
// ###########################
// Read line assembly, done pulse
// ###########################
`timescale 1ns/100ps

module bus_read_buffer (
   input  logic                 bus_clk,
   input  logic                 rst,
   input  bus_pkg::ctrl_state_t state,
   input  bus_pkg::beat_idx_t   beat,
   input  logic                 ack,
   input  bus_pkg::bus_word_t   rdata_word,
   output bus_pkg::line_t       rdata,
   output logic                 done
);
   import bus_pkg::*;

   line_t line_buf;
   line_t assembled;
   logic  take_word;
   logic  last_word;

   assign take_word = ack && (state == READ);
   assign last_word = ack && (beat == beat_idx_t'(BEATS - 1))
                      && ((state == WRITE) || (state == READ));

   // Current beat merged into the partial line
   always_comb begin
      assembled = line_buf;
      assembled[BUS_W*beat +: BUS_W] = rdata_word;
   end

   // Unit output only changes when a full read line is in
   always_ff @(posedge bus_clk) begin
      if (take_word) begin
         line_buf <= assembled;
      end
      if (take_word && last_word) begin
         rdata <= assembled;
      end
   end

   // Registered off the last ack, lands in DONE
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         done <= 1'b0;
      end else begin
         done <= last_word;
      end
   end

endmodule

//--- hw/bus_subsystem_top.sv
// ###########################
// Two controllers, arbiter, memory
// ###########################
`timescale 1ns/100ps

module bus_subsystem_top (
   input  logic               bus_clk,
   input  logic               rst,
   input  logic               en_0,
   input  logic               wr_0,
   input  bus_pkg::bus_addr_t addr_0,
   input  bus_pkg::line_t     wdata_0,
   output bus_pkg::line_t     rdata_0,
   output logic               done_0,
   input  logic               en_1,
   input  logic               wr_1,
   input  bus_pkg::bus_addr_t addr_1,
   input  bus_pkg::line_t     wdata_1,
   output bus_pkg::line_t     rdata_1,
   output logic               done_1
);
   // One bus per controller, one toward memory
   sys_bus_if bus_0 ();
   sys_bus_if bus_1 ();
   sys_bus_if bus_mem ();

   logic br_0;
   logic br_1;
   logic bg_0;
   logic bg_1;

   intr_bus_controller ctrl_0_inst (
      .bus_clk (bus_clk),
      .rst     (rst),
      .en      (en_0),
      .wr      (wr_0),
      .addr    (addr_0),
      .wdata   (wdata_0),
      .bg      (bg_0),
      .br      (br_0),
      .rdata   (rdata_0),
      .done    (done_0),
      .bus     (bus_0.master)
   );

   intr_bus_controller ctrl_1_inst (
      .bus_clk (bus_clk),
      .rst     (rst),
      .en      (en_1),
      .wr      (wr_1),
      .addr    (addr_1),
      .wdata   (wdata_1),
      .bg      (bg_1),
      .br      (br_1),
      .rdata   (rdata_1),
      .done    (done_1),
      .bus     (bus_1.master)
   );

   bus_arbiter bus_arbiter_inst (
      .bus_clk (bus_clk),
      .rst     (rst),
      .br_0    (br_0),
      .br_1    (br_1),
      .bg_0    (bg_0),
      .bg_1    (bg_1),
      .m0      (bus_0.slave),
      .m1      (bus_1.slave),
      .mem     (bus_mem.master)
   );

   mem_slave mem_slave_inst (
      .bus_clk (bus_clk),
      .rst     (rst),
      .bus     (bus_mem.slave)
   );

endmodule

//--- hw/intr_bus_controller.sv
// ###########################
// Work-unit bus controller
// ###########################
`timescale 1ns/100ps

module intr_bus_controller (
   input  logic               bus_clk,
   input  logic               rst,
   input  logic               en,
   input  logic               wr,
   input  bus_pkg::bus_addr_t addr,
   input  bus_pkg::line_t     wdata,
   input  logic               bg,
   output logic               br,
   output bus_pkg::line_t     rdata,
   output logic               done,
   sys_bus_if.master          bus
);
   import bus_pkg::*;

   ctrl_state_t state;
   beat_idx_t   beat;
   logic        last_beat;
   logic        req_wr;
   bus_addr_t   req_addr;
   line_t       req_wdata;
   logic        accept;

   // Unit request only taken while idle
   assign accept = en && (state == IDLE);

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         req_wr <= 1'b0;
      end else if (accept) begin
         req_wr <= wr;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (accept) begin
         req_addr  <= addr;
         req_wdata <= wdata;
      end
   end

   bus_ctrl_fsm bus_ctrl_fsm_inst (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .en        (en),
      .wr        (req_wr),
      .bg        (bg),
      .last_beat (last_beat),
      .br        (br),
      .state     (state)
   );

   bus_beat_engine bus_beat_engine_inst (
      .bus_clk    (bus_clk),
      .rst        (rst),
      .state      (state),
      .wdata_line (req_wdata),
      .req_addr   (req_addr),
      .req_wr     (req_wr),
      .beat       (beat),
      .last_beat  (last_beat),
      .bus        (bus)
   );

   // Read words come straight off the bus return path
   bus_read_buffer bus_read_buffer_inst (
      .bus_clk    (bus_clk),
      .rst        (rst),
      .state      (state),
      .beat       (beat),
      .ack        (bus.ack),
      .rdata_word (bus.rdata),
      .rdata      (rdata),
      .done       (done)
   );

endmodule

//--- hw/mem_slave.sv
// ###########################
// Line memory on the bus slave side
// ###########################
`timescale 1ns/100ps

module mem_slave (
   input  logic     bus_clk,
   input  logic     rst,
   sys_bus_if.slave bus
);
   import bus_pkg::*;

   line_t     mem [MEM_LINES];
   line_idx_t idx;
   logic      rw_q;
   logic      rd_active;
   beat_idx_t beat;
   logic      wr_en;
   line_t     cur_line;

   // Write beats acked in the same cycle
   assign wr_en    = bus.wbeat & rw_q;
   assign cur_line = mem[idx];
   assign bus.ack  = wr_en | rd_active;
   // One read word per cycle in beat order
   assign bus.rdata = rd_active ? cur_line[BUS_W*beat +: BUS_W] : '0;

   // Line index from the address phase, byte offset dropped
   always_ff @(posedge bus_clk) begin
      if (bus.valid) begin
         idx <= bus.addr[LINE_OFS +: IDX_W];
      end
   end

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         rw_q      <= 1'b0;
         rd_active <= 1'b0;
         beat      <= '0;
      end else if (bus.valid) begin
         rw_q      <= bus.rw;
         // Read burst starts the cycle after valid
         rd_active <= !bus.rw;
         beat      <= '0;
      end else if (bus.ack) begin
         beat <= beat + 1'b1;
         if (beat == beat_idx_t'(BEATS - 1)) begin
            rd_active <= 1'b0;
         end
      end
   end

   // Acked write word lands in its slot of the line
   always_ff @(posedge bus_clk) begin
      if (wr_en) begin
         mem[idx][BUS_W*beat +: BUS_W] <= bus.wdata;
      end
   end

   // Write beats only follow a write address phase
   a_wbeat_in_write: assert property (
      @(posedge bus_clk) disable iff (rst)
      bus.wbeat |-> rw_q
   ) else $error("FAILED %0t: write beat without write address phase", $time);

   // Arbiter keeps a new address phase out of a read burst
   a_no_valid_in_read: assert property (
      @(posedge bus_clk) disable iff (rst)
      bus.valid |-> !rd_active
   ) else $error("FAILED %0t: address phase during read burst", $time);

endmodule

//--- hw/sys_bus_if.sv
// ###########################
// Point-to-point system bus with
// master and slave views
// ###########################
`timescale 1ns/100ps

interface sys_bus_if;
   import bus_pkg::*;

   // Address phase strobe, one cycle per transfer
   logic      valid;
   bus_addr_t addr;
   // High for a write transfer
   logic      rw;
   bus_word_t wdata;
   // Write beat strobe, held until ack
   logic      wbeat;
   bus_word_t rdata;
   // Beat acknowledge from the slave
   logic      ack;

   modport master (
      output valid, addr, rw, wdata, wbeat,
      input  rdata, ack
   );

   modport slave (
      input  valid, addr, rw, wdata, wbeat,
      output rdata, ack
   );

endinterface

//--- test/tb_bus_subsystem.sv
// ###########################
// Subsystem testbench, reference
// line model and checking assertions
// ###########################
`timescale 1ns/100ps

module tb_bus_subsystem;
   import bus_pkg::*;

   // About 50 transfers, under 25 cycles each even with contention
   localparam int MAX_CYCLES = 2000;

   logic      bus_clk;
   logic      rst;
   logic      en_0;
   logic      wr_0;
   bus_addr_t addr_0;
   line_t     wdata_0;
   line_t     rdata_0;
   logic      done_0;
   logic      en_1;
   logic      wr_1;
   bus_addr_t addr_1;
   line_t     wdata_1;
   line_t     rdata_1;
   logic      done_1;

   integer    seed;
   int        errors;
   int        reads;
   int        dones;
   int        cycles;
   logic      started;

   // Request in flight per unit, as issued
   logic      pend_wr_0;
   bus_addr_t pend_addr_0;
   line_t     pend_data_0;
   logic      pend_wr_1;
   bus_addr_t pend_addr_1;
   line_t     pend_data_1;
   logic      busy_0;
   logic      busy_1;

   // Reference lines, indexed by address bits 9 to 4
   line_t     ref_mem [MEM_LINES];
   logic      known [MEM_LINES];
   line_t     exp_0;
   line_t     exp_1;

   bus_subsystem_top bus_subsystem_top_inst (
      .bus_clk (bus_clk),
      .rst     (rst),
      .en_0    (en_0),
      .wr_0    (wr_0),
      .addr_0  (addr_0),
      .wdata_0 (wdata_0),
      .rdata_0 (rdata_0),
      .done_0  (done_0),
      .en_1    (en_1),
      .wr_1    (wr_1),
      .addr_1  (addr_1),
      .wdata_1 (wdata_1),
      .rdata_1 (rdata_1),
      .done_1  (done_1)
   );

   initial begin
      bus_clk = 1'b0;
      forever #5 bus_clk = ~bus_clk;
   end

   assign exp_0 = ref_mem[pend_addr_0[9:4]];
   assign exp_1 = ref_mem[pend_addr_1[9:4]];

   // Model follows the order in which done pulses arrive
   always @(posedge bus_clk) begin
      if (done_0) begin
         dones <= dones + 1;
         known[pend_addr_0[9:4]] <= 1'b1;
         if (pend_wr_0) begin
            ref_mem[pend_addr_0[9:4]] <= pend_data_0;
         end else begin
            reads <= reads + 1;
         end
      end
      if (done_1) begin
         dones <= dones + 1;
         known[pend_addr_1[9:4]] <= 1'b1;
         if (pend_wr_1) begin
            ref_mem[pend_addr_1[9:4]] <= pend_data_1;
         end else begin
            reads <= reads + 1;
         end
      end
   end

   // One request outstanding per unit
   always @(posedge bus_clk) begin
      if (rst) begin
         busy_0 <= 1'b0;
         busy_1 <= 1'b0;
      end else begin
         if (en_0) busy_0 <= 1'b1;
         else if (done_0) busy_0 <= 1'b0;
         if (en_1) busy_1 <= 1'b1;
         else if (done_1) busy_1 <= 1'b0;
      end
   end

   always @(posedge bus_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   a_idle_done: assert property (
      @(posedge bus_clk) disable iff (rst)
      !started |-> !done_0 && !done_1
   ) else begin
      $display("FAILED %0t: done pulse before any request", $time);
      errors++;
   end

   a_read_0: assert property (
      @(posedge bus_clk) disable iff (rst)
      done_0 && !pend_wr_0 |-> rdata_0 == exp_0
   ) else begin
      $display("FAILED %0t: unit 0 read %h, expected %h", $time, rdata_0, exp_0);
      errors++;
   end

   a_read_1: assert property (
      @(posedge bus_clk) disable iff (rst)
      done_1 && !pend_wr_1 |-> rdata_1 == exp_1
   ) else begin
      $display("FAILED %0t: unit 1 read %h, expected %h", $time, rdata_1, exp_1);
      errors++;
   end

   a_pulse_0: assert property (@(posedge bus_clk) disable iff (rst) done_0 |=> !done_0)
      else begin
         $display("Unit 0 done stayed high for more than one cycle at %0t", $time);
         errors++;
      end

   a_pulse_1: assert property (@(posedge bus_clk) disable iff (rst) done_1 |=> !done_1)
      else begin
         $display("Unit 1 done stayed high for more than one cycle at %0t", $time);
         errors++;
      end

   a_owed_0: assert property (@(posedge bus_clk) disable iff (rst) done_0 |-> busy_0)
      else begin
         $display("Unit 0 got a done with no request in flight at %0t", $time);
         errors++;
      end

   a_owed_1: assert property (@(posedge bus_clk) disable iff (rst) done_1 |-> busy_1)
      else begin
         $display("Unit 1 got a done with no request in flight at %0t", $time);
         errors++;
      end

   function automatic line_t rand_line();
      line_t l;
      for (int i = 0; i < BEATS; i++) begin
         l[BUS_W*i +: BUS_W] = $random(seed);
      end
      return l;
   endfunction

   // One line transfer on one unit, back once the unit is idle again
   task automatic run_op(input int unit, input logic wr, input bus_addr_t addr,
                         input line_t data);
      logic got;
      started = 1'b1;
      if (unit == 0) begin
         pend_wr_0   = wr;
         pend_addr_0 = addr;
         pend_data_0 = data;
         wr_0        = wr;
         addr_0      = addr;
         wdata_0     = data;
         en_0        = 1'b1;
      end else begin
         pend_wr_1   = wr;
         pend_addr_1 = addr;
         pend_data_1 = data;
         wr_1        = wr;
         addr_1      = addr;
         wdata_1     = data;
         en_1        = 1'b1;
      end
      @(posedge bus_clk);
      #1;
      if (unit == 0) en_0 = 1'b0;
      else en_1 = 1'b0;
      got = 1'b0;
      while (!got) begin
         @(posedge bus_clk);
         #1;
         got = (unit == 0) ? done_0 : done_1;
      end
      // Controller leaves DONE one cycle later
      @(posedge bus_clk);
      #1;
   endtask

   initial begin
      logic [31:0] tmp;
      logic [1:0]  pick;
      logic        w0;
      logic        w1;
      bus_addr_t   a0;
      bus_addr_t   a1;
      line_t       d0;
      line_t       d1;
      line_t       keep;
      int          ops;
      seed    = 32'h0008e1f7;
      errors  = 0;
      reads   = 0;
      dones   = 0;
      cycles  = 0;
      started = 1'b0;
      rst     = 1'b1;
      en_0    = 1'b0;
      wr_0    = 1'b0;
      addr_0  = '0;
      wdata_0 = '0;
      en_1    = 1'b0;
      wr_1    = 1'b0;
      addr_1  = '0;
      wdata_1 = '0;
      pend_wr_0   = 1'b1;
      pend_addr_0 = '0;
      pend_data_0 = '0;
      pend_wr_1   = 1'b1;
      pend_addr_1 = '0;
      pend_data_1 = '0;
      for (int i = 0; i < MEM_LINES; i++) begin
         known[i] = 1'b0;
      end
      repeat (2) @(posedge bus_clk);
      #1;
      rst = 1'b0;

      // Quiet bus after reset
      repeat (6) @(posedge bus_clk);
      #1;

      // Write then read one line, upper and byte bits differ on the read
      d0 = rand_line();
      run_op(0, 1'b1, 16'h0120, d0);
      run_op(0, 1'b0, 16'hf12c, '0);

      // Same-cycle requests from both units
      d0 = rand_line();
      d1 = rand_line();
      fork
         run_op(0, 1'b1, 16'h0200, d0);
         run_op(1, 1'b1, 16'h0310, d1);
      join
      fork
         run_op(0, 1'b0, 16'h0200, '0);
         run_op(1, 1'b0, 16'h0310, '0);
      join

      // Neighbour line survives a later write
      keep = rand_line();
      run_op(1, 1'b1, 16'h0050, keep);
      run_op(1, 1'b1, 16'h0060, rand_line());
      run_op(0, 1'b0, 16'h0050, '0);
      run_op(1, 1'b0, 16'h0120, '0);

      // Random mix, reads only of lines the model already holds
      ops = 0;
      while (ops < 40) begin
         tmp  = $random(seed);
         pick = (tmp[1:0] == 2'd3) ? 2'd2 : tmp[1:0];
         if (ops == 39 && pick == 2'd2) pick = 2'd0;
         tmp = $random(seed);
         a0  = tmp[15:0];
         a1  = tmp[31:16];
         a0[9:7] = 3'b000;
         a1[9:7] = 3'b000;
         tmp = $random(seed);
         w0  = tmp[0] | !known[a0[9:4]];
         w1  = tmp[1] | !known[a1[9:4]];
         d0  = rand_line();
         d1  = rand_line();
         fork
            if (pick != 2'd1) run_op(0, w0, a0, d0);
            if (pick != 2'd0) run_op(1, w1, a1, d1);
         join
         ops = ops + ((pick == 2'd2) ? 2 : 1);
      end

      repeat (2) @(posedge bus_clk);
      $display("Errors: %0d  reads checked: %0d  done pulses: %0d", errors, reads, dones);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
